/* verilog/fpu_pkg.sv */
package fpu_pkg;

    // host opcodes where codes 2 and 3 give a zero result
    typedef enum logic [1:0] {
        op_add  = 2'd0,
        op_sub  = 2'd1,
        op_rsv2 = 2'd2,
        op_rsv3 = 2'd3
    } fpu_op_e;

    // sequencer states
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_norm = 2'd1,
        st_done = 2'd2
    } fpu_state_e;

endpackage

/* verilog/sum_if.sv */
`timescale 1ns/1ns

// raw significand sum handed from the aligner to the normalizer
interface sum_if #(
    parameter int EXP_W = 8,
    parameter int MAN_W = 23
);
    logic             sign;   // result sign
    logic [EXP_W-1:0] exp;    // exponent of the larger operand
    logic [MAN_W:0]   mant;   // hidden bit plus fraction
    logic             carry;  // carry out of the significand add

    modport src (
        output sign,
        output exp,
        output mant,
        output carry
    );

    modport dst (
        input sign,
        input exp,
        input mant,
        input carry
    );
endinterface

/* verilog/fp_align_add.sv */
`timescale 1ns/1ns

module fp_align_add #(
    parameter int EXP_W = 8,
    parameter int MAN_W = 23
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load,
    input  fpu_pkg::fpu_op_e     opcode,
    input  logic [EXP_W+MAN_W:0] float1,
    input  logic [EXP_W+MAN_W:0] float2,
    sum_if.src                   sum
);
    localparam int FP_W  = 1 + EXP_W + MAN_W;
    localparam int SIG_W = MAN_W + 1;

    logic [FP_W-1:0]  f1_swap;      // larger magnitude
    logic [FP_W-1:0]  f2_swap;      // smaller magnitude
    logic             swap_flag;
    logic             f1_sign;
    logic             f2_sign;
    logic [EXP_W-1:0] f1_exp;
    logic [EXP_W-1:0] f2_exp;
    logic [EXP_W-1:0] exp_diff;
    logic [SIG_W-1:0] f1_m;
    logic [SIG_W-1:0] f2_m;
    logic [SIG_W-1:0] f2_shift;
    logic [SIG_W-1:0] f2_rnd;
    logic             g_bit;
    logic             r_bit;
    logic             s_bit;
    logic             eff_sub;
    logic [SIG_W:0]   sum_raw;      // carry plus significand
    logic             sum_sign;

    // one bit of the smaller significand and zero when idx is out of range
    function automatic logic sig_bit(input logic [SIG_W-1:0] m, input int idx);
        return (idx >= 0 && idx < SIG_W) ? m[idx] : 1'b0;
    endfunction

    // exponent and fraction compare as one unsigned field
    // and equal magnitudes keep the original order
    assign swap_flag = float2[FP_W-2:0] > float1[FP_W-2:0];
    assign f1_swap   = swap_flag ? float2 : float1;
    assign f2_swap   = swap_flag ? float1 : float2;

    assign f1_sign = f1_swap[FP_W-1];
    assign f2_sign = f2_swap[FP_W-1];
    assign f1_exp  = f1_swap[FP_W-2:MAN_W];
    assign f2_exp  = f2_swap[FP_W-2:MAN_W];
    assign f1_m    = {1'b1, f1_swap[MAN_W-1:0]};  // hidden bit always set
    assign f2_m    = {1'b1, f2_swap[MAN_W-1:0]};

    assign exp_diff = f1_exp - f2_exp;

    // guard, round and sticky are the three bits just below the new lsb
    always_comb begin
        g_bit = sig_bit(f2_m, int'(exp_diff) - 1);
        r_bit = sig_bit(f2_m, int'(exp_diff) - 2);
        s_bit = sig_bit(f2_m, int'(exp_diff) - 3);
    end

    assign f2_shift = f2_m >> exp_diff;
    // round to nearest even while aligning
    assign f2_rnd = (g_bit & (r_bit | s_bit | f2_shift[0])) ? f2_shift + 1'b1 : f2_shift;

    // sub with equal signs, or add with unequal signs, is a true subtract
    assign eff_sub = (f1_sign ^ f2_sign) ^ (opcode == fpu_pkg::op_sub);

    always_comb begin
        if (eff_sub) begin
            sum_raw = {1'b0, f1_m} - {1'b0, f2_rnd};
        end else begin
            sum_raw = {1'b0, f1_m} + {1'b0, f2_rnd};
        end
    end

    // sub flips the sign when the operands were swapped
    assign sum_sign = (opcode == fpu_pkg::op_sub) ? (f1_sign ^ swap_flag) : f1_sign;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum.sign  <= 1'b0;
            sum.exp   <= '0;
            sum.mant  <= '0;
            sum.carry <= 1'b0;
        end else if (load) begin
            case (opcode)
                fpu_pkg::op_add, fpu_pkg::op_sub: begin
                    sum.sign             <= sum_sign;
                    sum.exp              <= f1_exp;
                    {sum.carry, sum.mant} <= sum_raw;
                end
                default: begin  // reserved codes
                    sum.sign  <= 1'b0;
                    sum.exp   <= '0;
                    sum.mant  <= '0;
                    sum.carry <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* verilog/fp_normalizer.sv */
`timescale 1ns/1ns

module fp_normalizer #(
    parameter int EXP_W = 8,
    parameter int MAN_W = 23
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 init,
    input  logic                 step,
    sum_if.dst                   sum,
    output logic                 msb,
    output logic [EXP_W+MAN_W:0] result
);
    logic             sign_q;
    logic [EXP_W-1:0] exp_q;
    logic [MAN_W:0]   mant_q;   // bit MAN_W is the hidden bit
    logic             zero_q;   // all-zero sum from a reserved opcode
    logic             sum_zero;

    assign sum_zero = !sum.sign && !sum.carry && (sum.exp == '0) && (sum.mant == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sign_q <= 1'b0;
            exp_q  <= '0;
            mant_q <= '0;
            zero_q <= 1'b0;
        end else if (init) begin
            sign_q <= sum.sign;
            zero_q <= sum_zero;
            if (sum.carry) begin
                // carry becomes the new hidden bit
                mant_q <= {1'b1, sum.mant[MAN_W:1]};
                exp_q  <= sum.exp + 1'b1;
            end else begin
                mant_q <= sum.mant;
                exp_q  <= sum.exp;
            end
        end else if (step) begin
            mant_q <= {mant_q[MAN_W-1:0], 1'b0};  // one leading zero out
            exp_q  <= exp_q - 1'b1;
        end
    end

    assign msb = mant_q[MAN_W];

    always_comb begin
        if (zero_q) begin
            result = '0;
        end else begin
            result = {sign_q, exp_q, mant_q[MAN_W-1:0]};  // hidden bit dropped
        end
    end

endmodule

/* verilog/fp_shift_counter.sv */
`timescale 1ns/1ns

module fp_shift_counter #(
    parameter int MAN_W = 23
) (
    input  logic clk,
    input  logic rst_n,
    input  logic load,
    input  logic step,
    output logic limit
);
    // an all-zero sum is shifted across the whole significand
    localparam int STEP_MAX = MAN_W + 1;
    localparam int CNT_W    = $clog2(STEP_MAX + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (load) begin
            count <= '0;  // new operation
        end else if (step && !limit) begin
            count <= count + 1'b1;
        end
    end

    assign limit = (count == CNT_W'(STEP_MAX));

endmodule

/* verilog/fpu_ctrl.sv */
`timescale 1ns/1ns

module fpu_ctrl #(
    parameter int EXP_W = 8,
    parameter int MAN_W = 23
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic                 msb,
    input  logic                 limit,
    output logic                 load,
    output logic                 init,
    output logic                 step,
    output logic                 busy,
    output logic                 done,
    input  logic [EXP_W+MAN_W:0] result_in,
    output logic [EXP_W+MAN_W:0] float_ans
);
    fpu_pkg::fpu_state_e state;
    fpu_pkg::fpu_state_e state_nxt;
    logic                finish;  // last normalize cycle

    always_comb begin
        load      = 1'b0;
        step      = 1'b0;
        state_nxt = state;
        case (state)
            fpu_pkg::st_idle: begin
                if (start) begin
                    load      = 1'b1;
                    state_nxt = fpu_pkg::st_norm;
                end
            end
            fpu_pkg::st_norm: begin
                // first cycle only loads the normalizer
                if (!init) begin
                    if (msb || limit) begin
                        state_nxt = fpu_pkg::st_done;
                    end else begin
                        step = 1'b1;
                    end
                end
            end
            fpu_pkg::st_done: state_nxt = fpu_pkg::st_idle;
            default:          state_nxt = fpu_pkg::st_idle;
        endcase
    end

    assign finish = (state == fpu_pkg::st_norm) && (state_nxt == fpu_pkg::st_done);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= fpu_pkg::st_idle;
            init      <= 1'b0;
            float_ans <= '0;
        end else begin
            state <= state_nxt;
            init  <= load;           // init follows load by one cycle
            if (finish) begin
                float_ans <= result_in;  // held until the next done
            end
        end
    end

    assign busy = (state != fpu_pkg::st_idle);
    assign done = (state == fpu_pkg::st_done);

endmodule

/* verilog/fpu_addsub_top.sv */
`timescale 1ns/1ns

module fpu_addsub_top #(
    parameter int EXP_W = 8,
    parameter int MAN_W = 23
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  fpu_pkg::fpu_op_e     opcode,
    input  logic [EXP_W+MAN_W:0] float1,
    input  logic [EXP_W+MAN_W:0] float2,
    output logic                 busy,
    output logic                 done,
    output logic [EXP_W+MAN_W:0] float_ans
);
    localparam int FP_W = 1 + EXP_W + MAN_W;

    logic            load;
    logic            init;
    logic            step;
    logic            msb;
    logic            limit;
    logic [FP_W-1:0] result;

    // aligner to normalizer
    sum_if #(
        .EXP_W (EXP_W),
        .MAN_W (MAN_W)
    ) u_sum ();

    fpu_ctrl #(
        .EXP_W (EXP_W),
        .MAN_W (MAN_W)
    ) u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .msb       (msb),
        .limit     (limit),
        .load      (load),
        .init      (init),
        .step      (step),
        .busy      (busy),
        .done      (done),
        .result_in (result),
        .float_ans (float_ans)
    );

    fp_align_add #(
        .EXP_W (EXP_W),
        .MAN_W (MAN_W)
    ) u_align (
        .clk    (clk),
        .rst_n  (rst_n),
        .load   (load),
        .opcode (opcode),
        .float1 (float1),
        .float2 (float2),
        .sum    (u_sum.src)
    );

    fp_normalizer #(
        .EXP_W (EXP_W),
        .MAN_W (MAN_W)
    ) u_norm (
        .clk    (clk),
        .rst_n  (rst_n),
        .init   (init),
        .step   (step),
        .sum    (u_sum.dst),
        .msb    (msb),
        .result (result)
    );

    // bounds the left-shift loop
    fp_shift_counter #(
        .MAN_W (MAN_W)
    ) u_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (load),
        .step  (step),
        .limit (limit)
    );

endmodule

/* test/tb_fpu_addsub.sv */
`timescale 1ns/1ns

module tb_fpu_addsub;
    localparam int EXP_W   = 8;
    localparam int MAN_W   = 23;
    localparam int FP_W    = 1 + EXP_W + MAN_W;
    localparam int TIMEOUT = 64;  // cycles allowed for one operation
    localparam int RST_CYC = 8;

    logic             clk;
    logic             rst_n;
    logic             start;
    fpu_pkg::fpu_op_e opcode;
    logic [FP_W-1:0]  float1;
    logic [FP_W-1:0]  float2;
    logic             busy;
    logic             done;
    logic [FP_W-1:0]  float_ans;

    fpu_addsub_top #(
        .EXP_W (EXP_W),
        .MAN_W (MAN_W)
    ) u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .opcode    (opcode),
        .float1    (float1),
        .float2    (float2),
        .busy      (busy),
        .done      (done),
        .float_ans (float_ans)
    );

    always #50 clk = ~clk;  // 100 ns period

    // print the reason, then the fail line, then stop
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    // one operation from start to done with an optional stray start while busy
    task automatic run_case(
        input int              idx,
        input logic [1:0]      op,
        input logic [FP_W-1:0] a,
        input logic [FP_W-1:0] b,
        input logic [FP_W-1:0] expect_val,
        input bit              poke_busy
    );
        int waited;
        @(posedge clk);
        start  <= 1'b1;
        opcode <= fpu_pkg::fpu_op_e'(op);
        float1 <= a;
        float2 <= b;
        @(posedge clk);
        if (poke_busy) begin
            // start stays high with other operands while the unit is in normalize
            opcode <= fpu_pkg::op_sub;
            float1 <= ~a;
            float2 <= ~b;
            @(negedge clk);
            assert (busy === 1'b1)
                else abort_run($sformatf("mismatch busy got %h expected 1 in case %0d",
                                         busy, idx));
            @(posedge clk);
        end
        start <= 1'b0;

        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (done !== 1'b1 && waited < TIMEOUT);
        assert (done === 1'b1)
            else abort_run($sformatf("done never arrived within %0d cycles in case %0d",
                                     TIMEOUT, idx));

        assert (float_ans === expect_val)
            else abort_run($sformatf("mismatch float_ans got %h expected %h in case %0d",
                                     float_ans, expect_val, idx));

        // done lasts one cycle and the result is held afterwards
        @(negedge clk);
        assert (done === 1'b0)
            else abort_run($sformatf("mismatch done got %h expected 0 after case %0d",
                                     done, idx));
        assert (busy === 1'b0)
            else abort_run($sformatf("mismatch busy got %h expected 0 after case %0d",
                                     busy, idx));
        assert (float_ans === expect_val)
            else abort_run($sformatf(
                "mismatch float_ans got %h expected %h after done of case %0d",
                float_ans, expect_val, idx));
    endtask

    initial begin
        int              fd;
        int              got;
        int              fields;
        int              n_cases;
        string           line;
        logic [1:0]      op_val;
        logic [FP_W-1:0] a_val;
        logic [FP_W-1:0] b_val;
        logic [FP_W-1:0] exp_val;

        clk     = 1'b0;
        rst_n   = 1'b0;
        start   = 1'b0;
        opcode  = fpu_pkg::op_add;
        float1  = '0;
        float2  = '0;
        n_cases = 0;

        repeat (RST_CYC) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        assert (busy === 1'b0)
            else abort_run($sformatf("mismatch busy got %h expected 0 after reset", busy));
        assert (done === 1'b0)
            else abort_run($sformatf("mismatch done got %h expected 0 after reset", done));
        assert (float_ans === '0)
            else abort_run($sformatf("mismatch float_ans got %h expected 0 after reset",
                                     float_ans));

        fd = $fopen("test/fpu_golden.txt", "r");
        assert (fd != 0)
            else abort_run("golden file test/fpu_golden.txt could not be opened");

        while (!$feof(fd)) begin
            got = $fgets(line, fd);
            if (got > 0) begin
                fields = $sscanf(line, "%h %h %h %h", op_val, a_val, b_val, exp_val);
                if (fields == 4) begin  // comment and blank lines give fewer fields
                    run_case(n_cases, op_val, a_val, b_val, exp_val, n_cases[0]);
                    n_cases++;
                end
            end
        end
        $fclose(fd);

        if (n_cases == 0) begin
            abort_run("golden file holds no cases");
        end else begin
            $display("%0d cases checked", n_cases);
            $display("test passed");
            $finish;
        end
    end

endmodule

/* fpu_addsub.f */
verilog/fpu_pkg.sv
verilog/sum_if.sv
verilog/fp_align_add.sv
verilog/fp_normalizer.sv
verilog/fp_shift_counter.sv
verilog/fpu_ctrl.sv
verilog/fpu_addsub_top.sv
test/tb_fpu_addsub.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fpu_addsub \
    -f fpu_addsub.f \
    -o tb_fpu_addsub_sim \
    && ./obj_dir/tb_fpu_addsub_sim \
    || exit 1

/* test/fpu_golden.txt */
# columns: opcode (0 add, 1 sub, 2 and 3 reserved), operand a, operand b, expected result
# all values in hex, single precision
# same-sign add, carry out and right shift
0 3F800000 3F800000 40000000
0 3FC00000 3FC00000 40400000
0 3F800000 40000000 40400000
0 BF800000 BF800000 C0000000
0 40400000 3FC00000 40900000
0 3FFFFFFF 3FFFFFFF 407FFFFF
# sub of opposite signs becomes an add with carry
1 3FC00000 BFC00000 40400000
# different-sign add
0 3F800000 BF400000 3E800000
0 C0000000 3F800000 BF800000
0 3F800000 C0000000 BF800000
# nearby values, long left shift and the step limit
1 3F800001 3F800000 34000000
1 40400000 40000000 3F800000
1 3F800000 3F800000 33800000
# sub with swapped operands flips the sign
1 3F800000 3F800001 B4000000
1 40000000 40400000 BF800000
# alignment rounding, exponent difference 1
0 40000000 3F800003 40400002
0 40000000 3F800001 40400000
1 40000000 3F800003 3F7FFFF8
# exponent difference 2
0 40800000 3F800002 40A00000
0 40800000 3F800003 40A00001
0 40800000 3F800006 40A00002
# exponent difference 3
0 41000000 3F800004 41100000
0 41000000 3F800005 41100001
# exponent difference 5, sticky looks at one bit only
0 42000000 3F800011 42040000
0 42000000 3F800014 42040001
# exponent difference 24 and 30
0 3F800000 33C00000 3F800001
0 3F800000 30800000 3F800000
# reserved opcodes
2 3F800000 3F800000 00000000
3 40400000 BF800000 00000000
